// File: dv/req_stimulus.txt
# op addr len count stride mode: op 0 read, 1 write, 2 sync; a run steps addr by stride, len by 1.
# mode 0 random gaps and back-pressure, 1 back-to-back with m_ready high, 2 m_ready low 20 cycles.
0 000000000000 0000010 4 1000 0
1 00007fff3000 0000100 4 1000 0
2 123456789000 0000000 2 0 0
0 0000abcd1040 0000020 8 4000 0
1 00000000a000 fffff00 3 1000 2
0 ffffffff0000 0000001 6 1000 0
1 000000002000 0000200 12 40 1
2 000000000000 0000000 1 0 0
0 000010003000 0000400 10 4000 0
1 00000000c000 0000008 5 1000 0
0 0000ffff1000 0000010 16 40 1
2 000000005000 0000000 2 1000 0
1 000000004000 0000080 8 1000 2
0 00000000e000 0000030 7 4000 0
1 800000000000 7ffffff 4 1000 0
0 000000003000 0000100 10 40 1
2 000000001000 0000000 3 2000 0
1 00000007f000 0000050 6 1000 0
0 000000000000 0000060 8 8000 0
1 000000006000 0000070 5 1000 2
0 000000011000 0000080 4 1000 0

// File: tb.f
verilog/req_pkg.sv
verilog/req_intf.sv
verilog/req_dispatch.sv
verilog/req_reg.sv
verilog/req_arbiter.sv
verilog/req_route_top.sv
dv/tb_req_route.sv

// File: Bender.yml
package:
  name: req_route

sources:
  # Design sources in compile order.
  - files:
      - verilog/req_pkg.sv
      - verilog/req_intf.sv
      - verilog/req_dispatch.sv
      - verilog/req_reg.sv
      - verilog/req_arbiter.sv
      - verilog/req_route_top.sv

  # Testbench, top module tb_req_route.
  - target: simulation
    files:
      - dv/tb_req_route.sv

// File: dv/tb_req_route.sv
`timescale 1ns/1ps

module tb_req_route import req_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int STALL_CYCLES = 20;
    localparam int DRAIN_CYCLES = 400;
    localparam logic [31:0] SEED = 32'hd510905c;

    logic                  aclk;
    logic                  aresetn;
    logic                  s_valid;
    logic                  s_ready;
    req_opcode_t           s_opcode;
    logic [VADDR_BITS-1:0] s_vaddr;
    logic [LEN_BITS-1:0]   s_len;
    logic                  m_valid;
    logic                  m_ready;
    req_opcode_t           m_opcode;
    logic [VADDR_BITS-1:0] m_vaddr;
    logic [LEN_BITS-1:0]   m_len;
    req_id_t               m_id;

    req_t        req_list [$];   // Every request of the file, runs expanded.
    int          mode_list [$];
    bit          run_first [$];
    int          pend_q [$];     // Accepted request numbers still in flight.
    int          n_req, in_count, out_count;
    int          req_errors, id_errors, other_errors;
    bit          loaded, force_high;
    int          hold_low;
    logic [31:0] gap_state, bp_state;

    req_route_top u_req_route_top (.*);

    always #20 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Channel field of the address, bits CHAN_LSB and up.
    function automatic logic [CHAN_BITS-1:0] chan_of(input req_t r);
        return r.vaddr[CHAN_LSB +: CHAN_BITS];
    endfunction

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic check_req(input req_t got, input req_t exp, input int idx);
        if (got.opcode !== exp.opcode) begin
            req_errors++;
            $display("** Error at %0t: request %0d opcode is %0d, expected %0d",
                     $time, idx, got.opcode, exp.opcode);
        end
        if (got.vaddr !== exp.vaddr) begin
            req_errors++;
            $display("** Error at %0t: request %0d vaddr is %h, expected %h",
                     $time, idx, got.vaddr, exp.vaddr);
        end
        if (got.len !== exp.len) begin
            req_errors++;
            $display("** Error at %0t: request %0d len is %h, expected %h",
                     $time, idx, got.len, exp.len);
        end
    endtask

    task automatic check_id(input req_id_t got, input req_id_t exp, input int idx);
        if (got !== exp) begin
            id_errors++;
            $display("** Error at %0t: request %0d id is %0d, expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    task automatic read_stimulus();
        int          fd, code, op, cnt, mode;
        string       line;
        logic [47:0] addr, stride;
        logic [27:0] len;
        req_t        r;
        fd = $fopen("dv/req_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file dv/req_stimulus.txt.");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %h %h %d %h %d", op, addr, len, cnt, stride, mode);
                    for (int k = 0; code == 6 && k < cnt; k++) begin
                        r.opcode = req_opcode_t'(op);
                        r.vaddr  = addr + stride * 48'(k);
                        r.len    = len + 28'(k);
                        req_list.push_back(r);
                        mode_list.push_back(mode);
                        run_first.push_back(k == 0);
                    end
                end
            end
            $fclose(fd);
        end
        n_req = req_list.size();
    endtask

    // ##################################################
    // Driver and back-pressure
    // ##################################################

    // Called on a falling edge, returns on the falling edge after the transfer.
    task automatic drive_one(input int i);
        int gaps;
        int waits;
        if (run_first[i]) begin
            s_valid = 1'b0;
            @(posedge aclk);   // Back-pressure settings change on the rising edge.
            force_high = (mode_list[i] == 1);
            if (mode_list[i] == 2)
                hold_low = STALL_CYCLES;
            @(negedge aclk);
            if (mode_list[i] == 1) begin
                while (pend_q.size() != 0) @(negedge aclk);   // Start from empty slices.
            end
        end
        if (mode_list[i] != 1) begin
            gap_state = lcg_next(gap_state);
            gaps = gap_state[31:30];
            s_valid = 1'b0;
            repeat (gaps) @(negedge aclk);
        end
        s_valid  = 1'b1;
        s_opcode = req_list[i].opcode;
        s_vaddr  = req_list[i].vaddr;
        s_len    = req_list[i].len;
        waits = 0;
        @(posedge aclk);
        while (!s_ready) begin
            waits++;
            @(posedge aclk);
        end
        if (mode_list[i] == 1 && !run_first[i] && waits != 0) begin
            other_errors++;
            $display("At %0t the input stalled %0d cycles inside a back-to-back run.",
                     $time, waits);
        end
        @(negedge aclk);
    endtask

    always @(negedge aclk) begin : back_pressure
        if (hold_low > 0) begin
            m_ready = 1'b0;
            hold_low--;
        end else if (force_high) begin
            m_ready = 1'b1;
        end else begin
            bp_state = lcg_next(bp_state);
            m_ready = (bp_state[31:30] != 2'b00);
        end
    end

    // ##################################################
    // Scoreboard
    // ##################################################

    always @(posedge aclk) begin : scoreboard
        int                   pos;
        req_t                 got;
        logic [CHAN_BITS-1:0] out_chan;
        pos = -1;
        got.opcode = m_opcode;
        got.vaddr  = m_vaddr;
        got.len    = m_len;
        out_chan   = m_vaddr[CHAN_LSB +: CHAN_BITS];
        if (aresetn && s_valid && s_ready) begin
            pend_q.push_back(in_count);   // The request number gives the expected id.
            in_count++;
        end
        if (aresetn && m_valid && m_ready) begin
            for (int k = 0; k < pend_q.size(); k++) begin
                if (pos < 0 && chan_of(req_list[pend_q[k]]) == out_chan)
                    pos = k;
            end
            if (pos < 0) begin
                other_errors++;
                $display("At %0t a request left on channel %0d with none pending there.",
                         $time, out_chan);
            end else begin
                check_req(got, req_list[pend_q[pos]], pend_q[pos]);
                check_id(m_id, req_id_t'(pend_q[pos] % (1 << N_ID_BITS)), pend_q[pos]);
                pend_q.delete(pos);
            end
            out_count++;
        end
    end

    task automatic report_counts();
        $display("Errors: request=%0d id=%0d other=%0d (%0d in, %0d out)",
                 req_errors, id_errors, other_errors, in_count, out_count);
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (n_req * 20 + 200) @(posedge aclk);
        $display("Timeout after %0d cycles with %0d requests still pending.",
                 n_req * 20 + 200, pend_q.size());
        report_counts();
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        aclk = 1'b0;
        aresetn = 1'b0;
        s_valid = 1'b0;
        s_opcode = REQ_READ;
        s_vaddr = '0;
        s_len = '0;
        m_ready = 1'b0;
        force_high = 1'b0;
        hold_low = RESET_CYCLES;   // Keeps m_ready low through reset.
        gap_state = SEED;
        bp_state = lcg_next(SEED);
        read_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge aclk);
            if (s_ready !== 1'b0 || m_valid !== 1'b0) begin
                other_errors++;
                $display("At %0t s_ready or m_valid was not low during reset.", $time);
            end
        end
        aresetn = 1'b1;
        for (int i = 0; i < n_req; i++)
            drive_one(i);
        s_valid = 1'b0;
        @(posedge aclk);
        force_high = 1'b1;   // Let everything drain.
        repeat (DRAIN_CYCLES) begin
            @(negedge aclk);
            if (pend_q.size() == 0)
                break;
        end
        if (pend_q.size() != 0 || out_count != n_req) begin
            other_errors++;
            $display("%0d requests never left the design.", pend_q.size());
        end
        report_counts();
        if (req_errors + id_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/req_route_top.sv
`timescale 1ns/1ps

module req_route_top import req_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,

    // Request input.
    input  logic                  s_valid,
    output logic                  s_ready,
    input  req_opcode_t           s_opcode,
    input  logic [VADDR_BITS-1:0] s_vaddr,
    input  logic [LEN_BITS-1:0]   s_len,

    // Merged request output.
    output logic                  m_valid,
    input  logic                  m_ready,
    output req_opcode_t           m_opcode,
    output logic [VADDR_BITS-1:0] m_vaddr,
    output logic [LEN_BITS-1:0]   m_len,
    output req_id_t               m_id
);

    req_t s_req;
    req_t m_req;

    req_intf ch_in [N_CHAN] ();
    req_intf ch_out [N_CHAN] ();

    assign s_req.opcode = s_opcode;
    assign s_req.vaddr  = s_vaddr;
    assign s_req.len    = s_len;

    assign m_opcode = m_req.opcode;
    assign m_vaddr  = m_req.vaddr;
    assign m_len    = m_req.len;

    // ##################################################
    // Dispatch, per-channel slices, merge
    // ##################################################

    req_dispatch u_dispatch (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_req   (s_req),
        .ch_in   (ch_in)
    );

    genvar i;
    generate
        for (i = 0; i < N_CHAN; i++) begin : g_slice
            req_reg u_reg (
                .aclk    (aclk),
                .aresetn (aresetn),
                .req_in  (ch_in[i]),
                .req_out (ch_out[i])
            );
        end
    endgenerate

    req_arbiter u_arbiter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ch_out  (ch_out),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_req   (m_req),
        .m_id    (m_id)
    );

endmodule

// File: verilog/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter import req_pkg::*; (
    input  logic    aclk,
    input  logic    aresetn,

    req_intf.s      ch_out [N_CHAN],

    output logic    m_valid,
    input  logic    m_ready,
    output req_t    m_req,
    output req_id_t m_id
);

    logic [N_CHAN-1:0]    ch_valid;
    req_t                 ch_req [N_CHAN];
    req_id_t              ch_id [N_CHAN];

    logic [CHAN_BITS-1:0] ptr_q;
    logic [CHAN_BITS-1:0] search;
    logic [CHAN_BITS-1:0] grant;
    logic                 lock_q;
    logic [CHAN_BITS-1:0] lock_chan_q;
    logic                 m_fire;

    // ##################################################
    // Channel gather and ready return
    // ##################################################

    genvar i;
    generate
        for (i = 0; i < N_CHAN; i++) begin : g_chan
            assign ch_valid[i]     = ch_out[i].valid;
            assign ch_req[i]       = ch_out[i].req;
            assign ch_id[i]        = ch_out[i].id;
            assign ch_out[i].ready = m_ready && m_valid && (grant == CHAN_BITS'(i));
        end
    endgenerate

    // ##################################################
    // Round-robin search
    // ##################################################

    always_comb begin : rr_search
        logic                 found;
        logic [CHAN_BITS-1:0] idx;
        found  = 1'b0;
        search = ptr_q;
        for (int k = 0; k < N_CHAN; k++) begin
            idx = ptr_q + CHAN_BITS'(k);   // Wraps around the channel count.
            if (!found && ch_valid[idx]) begin
                found  = 1'b1;
                search = idx;
            end
        end
    end

    // A stalled grant is held, so a newly valid channel cannot steal the port.
    assign grant   = lock_q ? lock_chan_q : search;

    assign m_valid = ch_valid[grant];
    assign m_req   = ch_req[grant];
    assign m_id    = ch_id[grant];
    assign m_fire  = m_valid && m_ready;

    always_ff @(posedge aclk, negedge aresetn) begin
        if (!aresetn) begin
            ptr_q       <= '0;
            lock_q      <= 1'b0;
            lock_chan_q <= '0;
        end else begin
            lock_q      <= m_valid && !m_ready;
            lock_chan_q <= grant;
            if (m_fire)
                ptr_q <= grant + 1'b1;   // Winner drops to lowest priority.
        end
    end

endmodule

// File: verilog/req_reg.sv
`timescale 1ns/1ps

module req_reg import req_pkg::*; (
    input  logic    aclk,
    input  logic    aresetn,

    req_intf.s      req_in,
    req_intf.m      req_out
);

    logic    in_ready_q, in_ready_d;

    logic    out_valid_q, out_valid_d;
    req_t    out_req_q, out_req_d;
    req_id_t out_id_q, out_id_d;

    logic    tmp_valid_q, tmp_valid_d;
    req_t    tmp_req_q, tmp_req_d;
    req_id_t tmp_id_q, tmp_id_d;

    // Ready stays high unless the skid entry is taken or is about to be.
    assign in_ready_d = req_out.ready || (!tmp_valid_q && (!out_valid_q || !req_in.valid));

    always_comb begin
        out_valid_d = out_valid_q;
        out_req_d   = out_req_q;
        out_id_d    = out_id_q;
        tmp_valid_d = tmp_valid_q;
        tmp_req_d   = tmp_req_q;
        tmp_id_d    = tmp_id_q;

        if (in_ready_q) begin
            if (req_out.ready || !out_valid_q) begin
                out_valid_d = req_in.valid;
                out_req_d   = req_in.req;
                out_id_d    = req_in.id;
            end else begin
                // Output is stalled, so park the new request.
                tmp_valid_d = req_in.valid;
                tmp_req_d   = req_in.req;
                tmp_id_d    = req_in.id;
            end
        end else if (req_out.ready) begin
            out_valid_d = tmp_valid_q;   // Drain the skid entry first.
            out_req_d   = tmp_req_q;
            out_id_d    = tmp_id_q;
            tmp_valid_d = 1'b0;
        end
    end

    always_ff @(posedge aclk, negedge aresetn) begin
        if (!aresetn) begin
            in_ready_q  <= 1'b0;
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            in_ready_q  <= in_ready_d;
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end
    end

    always_ff @(posedge aclk) begin
        out_req_q <= out_req_d;
        out_id_q  <= out_id_d;
        tmp_req_q <= tmp_req_d;
        tmp_id_q  <= tmp_id_d;
    end

    assign req_in.ready  = in_ready_q;

    assign req_out.valid = out_valid_q;
    assign req_out.req   = out_req_q;
    assign req_out.id    = out_id_q;

endmodule

// File: verilog/req_dispatch.sv
`timescale 1ns/1ps

module req_dispatch import req_pkg::*; (
    input  logic    aclk,
    input  logic    aresetn,

    input  logic    s_valid,
    output logic    s_ready,
    input  req_t    s_req,

    req_intf.m      ch_in [N_CHAN]
);

    logic [CHAN_BITS-1:0] chan;
    logic [N_CHAN-1:0]    ch_ready;
    logic                 s_fire;
    req_id_t              id_q;

    // ##################################################
    // Channel decode
    // ##################################################

    assign chan = s_req.vaddr[CHAN_LSB +: CHAN_BITS];

    genvar i;
    generate
        for (i = 0; i < N_CHAN; i++) begin : g_chan
            // Only the addressed channel sees valid, the rest just see the bundle.
            assign ch_in[i].valid = s_valid && (chan == CHAN_BITS'(i));
            assign ch_in[i].req   = s_req;
            assign ch_in[i].id    = id_q;
            assign ch_ready[i]    = ch_in[i].ready;
        end
    endgenerate

    assign s_ready = ch_ready[chan];   // Follows the channel picked by the current address.
    assign s_fire  = s_valid && s_ready;

    // ##################################################
    // Id counter
    // ##################################################

    always_ff @(posedge aclk, negedge aresetn) begin
        if (!aresetn) begin
            id_q <= '0;
        end else if (s_fire) begin
            id_q <= id_q + 1'b1;   // Wraps on its own at 2**N_ID_BITS.
        end
    end

endmodule

// File: verilog/req_intf.sv
`timescale 1ns/1ps

interface req_intf import req_pkg::*; ();

    logic    valid;
    logic    ready;
    req_t    req;
    req_id_t id;

    // Sender side.
    modport m (
        output valid,
        output req,
        output id,
        input  ready
    );

    // Receiver side.
    modport s (
        input  valid,
        input  req,
        input  id,
        output ready
    );

endinterface

// File: verilog/req_pkg.sv
package req_pkg;

    // ##################################################
    // Sizes
    // ##################################################

    localparam int N_CHAN     = 4;
    localparam int CHAN_BITS  = 2;
    localparam int VADDR_BITS = 48;
    localparam int CHAN_LSB   = 12;   // Each 4 KiB page maps to the next channel in turn.
    localparam int LEN_BITS   = 28;
    localparam int N_ID_BITS  = 6;    // Ids wrap modulo 64.

    // ##################################################
    // Types
    // ##################################################

    typedef enum logic [1:0] {
        REQ_READ  = 2'b00,
        REQ_WRITE = 2'b01,
        REQ_SYNC  = 2'b10
    } req_opcode_t;

    // One memory request as seen by the front end.
    typedef struct packed {
        req_opcode_t             opcode;
        logic [VADDR_BITS-1:0]   vaddr;
        logic [LEN_BITS-1:0]     len;
    } req_t;

    // The id travels next to the request, not inside it.
    typedef logic [N_ID_BITS-1:0] req_id_t;

endpackage
